// ==== Makefile ====
# Verilator build and run for the booth multiplier testbench

VERILATOR ?= verilator
TOP ?= booth_mul_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/booth_mul_tb.sv ====
// iterative booth multiplier testbench with stimulus, product model, checks and timeout
`timescale 1ns/100ps

module booth_mul_tb;

  localparam int width_lp = 32;
  localparam int stride_lp = 8;
  localparam int cpa_stride_lp = 16;
  localparam int clk_period_lp = 40;
  localparam int drive_delay_lp = 2;
  // counted from the accepting edge itself through the edge that raises v_o
  localparam int latency_edges_lp = width_lp / stride_lp + width_lp / cpa_stride_lp + 1;
  localparam int random_count_lp = 150;
  localparam int stall_count_lp = 40;
  // about 390 requests, none longer than 13 cycles, most of them 8
  localparam int max_requests_lp = 400;
  localparam int cycles_per_request_lp = 12;
  localparam int timeout_cycles_lp = max_requests_lp * cycles_per_request_lp;

  logic clk_i;
  logic reset_i;
  logic [width_lp-1:0] opa_i;
  logic [width_lp-1:0] opb_i;
  logic signed_i;
  logic v_i;
  logic yumi_i;
  logic ready_o;
  logic [2*width_lp-1:0] result_o;
  logic v_o;

  logic [31:0] rng_state;
  int errors;
  int checks;
  int cycle_count;

  booth_mul_iterative #(
    .width_p(width_lp),
    .stride_p(stride_lp),
    .cpa_stride_p(cpa_stride_lp)
  ) dut_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .opa_i(opa_i),
    .opb_i(opb_i),
    .signed_i(signed_i),
    .v_i(v_i),
    .yumi_i(yumi_i),
    .ready_o(ready_o),
    .result_o(result_o),
    .v_o(v_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles_lp) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles_lp);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  // full product from operands extended to 64 bits
  function automatic logic [63:0] expected_product(input logic [31:0] a, input logic [31:0] b,
                                                   input logic sgn);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    ext_a = sgn ? {{32{a[31]}}, a} : {32'b0, a};
    ext_b = sgn ? {{32{b[31]}}, b} : {32'b0, b};
    return ext_a * ext_b;
  endfunction

  task automatic record_error(input string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  task automatic run_request(input logic [31:0] a, input logic [31:0] b, input logic sgn,
                             input int stall, input logic busy_pulse);
    logic [63:0] expected;
    logic [63:0] held;
    logic [31:0] junk;
    int edges;
    expected = expected_product(a, b, sgn);
    opa_i = a;
    opb_i = b;
    signed_i = sgn;
    v_i = 1'b1;
    checks++;
    if (!ready_o) begin
      record_error("ready_o low before a new request");
    end
    @(posedge clk_i);
    #drive_delay_lp;
    edges = 1;
    v_i = busy_pulse;
    if (busy_pulse) begin
      // different operands that must not be taken
      next_random(junk);
      opa_i = junk;
      next_random(junk);
      opb_i = junk;
      signed_i = ~sgn;
    end
    checks++;
    if (ready_o) begin
      record_error("ready_o still high after the accepting edge");
    end
    while (!v_o) begin
      @(posedge clk_i);
      #drive_delay_lp;
      edges++;
      v_i = 1'b0;
    end
    checks++;
    if (edges != latency_edges_lp) begin
      record_error($sformatf("v_o rose after %0d edges, expected %0d", edges, latency_edges_lp));
    end
    checks++;
    if (result_o !== expected) begin
      record_error($sformatf("%h * %h signed=%0b gave %h, expected %h",
                             a, b, sgn, result_o, expected));
    end
    held = result_o;
    repeat (stall) begin
      @(posedge clk_i);
      #drive_delay_lp;
      checks++;
      if (!v_o || ready_o || result_o !== held) begin
        record_error($sformatf("stall: v_o=%0b ready_o=%0b result %h, held %h",
                               v_o, ready_o, result_o, held));
      end
    end
    yumi_i = 1'b1;
    @(posedge clk_i);
    #drive_delay_lp;
    yumi_i = 1'b0;
    checks++;
    if (!ready_o || v_o) begin
      record_error($sformatf("after consume ready_o=%0b v_o=%0b", ready_o, v_o));
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] corners [5];
    reset_i = 1'b1;
    opa_i = '0;
    opb_i = '0;
    signed_i = 1'b0;
    v_i = 1'b0;
    yumi_i = 1'b0;
    errors = 0;
    checks = 0;
    rng_state = 32'hc725d8ed;
    corners[0] = 32'h0000_0000;
    corners[1] = 32'h0000_0001;
    corners[2] = 32'hffff_ffff;
    corners[3] = 32'h8000_0000;
    corners[4] = 32'h7fff_ffff;

    repeat (3) @(posedge clk_i);
    #drive_delay_lp;
    reset_i = 1'b0;

    checks++;
    if (!ready_o || v_o) begin
      record_error($sformatf("after reset ready_o=%0b v_o=%0b", ready_o, v_o));
    end

    for (int i = 0; i < random_count_lp; i++) begin
      next_random(a);
      next_random(b);
      run_request(a, b, 1'b0, 0, 1'b0);
    end

    for (int i = 0; i < random_count_lp; i++) begin
      next_random(a);
      next_random(b);
      run_request(a, b, 1'b1, 0, 1'b0);
    end

    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_request(corners[i], corners[j], m[0], 0, 1'b0);
        end
      end
    end

    // back-pressure with a rejected request during the busy phase
    for (int i = 0; i < stall_count_lp; i++) begin
      next_random(a);
      next_random(b);
      next_random(r);
      run_request(a, b, r[31], int'(r % 6), 1'b1);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/booth_pkg.sv
logic/booth_partial_product.sv
logic/booth_recoder.sv
logic/booth_compress_step.sv
logic/booth_accumulator.sv
logic/booth_final_adder.sv
logic/booth_mul_control.sv
logic/booth_mul_iterative.sv
bench/booth_mul_tb.sv

// ==== logic/booth_accumulator.sv ====
// multiplicand and digit queue, carry-save pair, low ripple fold and low result
`timescale 1ns/100ps

module booth_accumulator #(
  parameter int width_p = 32,
  parameter int stride_p = 8,
  parameter int cpa_stride_p = 16,
  localparam int csa_width_lp = stride_p + width_p + 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  input  logic calc_i,
  input  logic cpa_first_i,
  input  logic cpa_i,
  input  booth_pkg::booth_digit_t [width_p/2:0] digits_i,
  input  logic [width_p:0] opa_ext_i,
  input  logic [width_p+3:0] first_row_i,
  output logic [cpa_stride_p-1:0] chunk_a_o,
  output logic [cpa_stride_p-1:0] chunk_b_o,
  output logic tail_carry_o,
  output logic [width_p-1:0] result_low_o
);

  localparam int step_digits_lp = stride_p / 2;

  logic [width_p:0] opa_r;
  booth_pkg::booth_digit_t [width_p/2-1:0] queue_r;
  logic sign_fix_r;
  logic [csa_width_lp-1:0] sum_r;
  logic [csa_width_lp-1:0] carry_r;
  logic [width_p-1:0] result_low_r;
  logic [width_p-1:0] result_low_n;
  logic [csa_width_lp-1:0] step_sum;
  logic [csa_width_lp-1:0] step_carry;
  logic [stride_p:0] tail;

  booth_compress_step #(
    .width_p(width_p),
    .stride_p(stride_p)
  ) compress_i (
    .multiplicand_i(opa_r),
    .digits_i(queue_r[step_digits_lp-1:0]),
    .sum_i(sum_r),
    .carry_i(carry_r),
    .sign_fix_i(sign_fix_r),
    .sum_o(step_sum),
    .carry_o(step_carry)
  );

  // low bits of the pair are settled, resolve them here
  assign tail = {1'b0, sum_r[stride_p-1:0]} + {1'b0, carry_r[stride_p-1:0]};
  assign result_low_n = (result_low_r >> stride_p)
                      | (width_p'(tail[stride_p-1:0]) << (width_p - stride_p));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      queue_r <= '0;
      sign_fix_r <= 1'b0;
    end else if (start_i) begin
      queue_r <= digits_i[width_p/2:1];
      sign_fix_r <= digits_i[0].negative;
    end else if (calc_i) begin
      queue_r <= queue_r >> (booth_pkg::BOOTH_DIGIT_W * step_digits_lp);
      sign_fix_r <= queue_r[step_digits_lp-1].negative;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      opa_r <= opa_ext_i;
      sum_r <= {first_row_i, {stride_p{1'b0}}};
      carry_r <= '0;
    end else if (calc_i) begin
      sum_r <= step_sum;
      // bit 0 of a shifted carry word is free for the fold carry
      carry_r <= {step_carry[csa_width_lp-1:1], tail[stride_p]};
      result_low_r <= result_low_n;
    end else if (cpa_i) begin
      sum_r <= sum_r >> cpa_stride_p;
      carry_r <= carry_r >> cpa_stride_p;
      // last fold of the final iteration
      if (cpa_first_i) begin
        result_low_r <= result_low_n;
      end
    end
  end

  assign chunk_a_o = sum_r[stride_p +: cpa_stride_p];
  assign chunk_b_o = carry_r[stride_p +: cpa_stride_p];
  assign tail_carry_o = tail[stride_p];
  assign result_low_o = result_low_r;

endmodule

// ==== logic/booth_compress_step.sv ====
// one iteration of booth rows plus the carry-save pair, reduced by 3:2 adders
`timescale 1ns/100ps

module booth_compress_step #(
  parameter int width_p = 32,
  parameter int stride_p = 8,
  localparam int csa_width_lp = stride_p + width_p + 4
) (
  input  logic [width_p:0] multiplicand_i,
  input  booth_pkg::booth_digit_t [stride_p/2-1:0] digits_i,
  input  logic [csa_width_lp-1:0] sum_i,
  input  logic [csa_width_lp-1:0] carry_i,
  input  logic sign_fix_i,
  output logic [csa_width_lp-1:0] sum_o,
  output logic [csa_width_lp-1:0] carry_o
);

  localparam int rows_lp = stride_p / 2;

  logic [rows_lp+1:0][csa_width_lp-1:0] ops;
  logic [rows_lp:0][csa_width_lp-1:0] sum_w;
  logic [rows_lp:0][csa_width_lp-1:0] carry_w;

  for (genvar i = 0; i < rows_lp; i++) begin : g_row
    logic [width_p+2:0] row;
    logic correction;

    booth_partial_product #(
      .width_p(width_p),
      .initial_p(1'b0)
    ) pp_i (
      .multiplicand_i(multiplicand_i),
      .digit_i(digits_i[i]),
      .row_o(row)
    );

    // plus one for the previous row's negation
    if (i == 0) begin : g_first
      assign correction = sign_fix_i;
    end else begin : g_next
      assign correction = digits_i[i-1].negative;
    end

    assign ops[i] = csa_width_lp'({row, 1'b0, correction}) << (2 * i);
  end

  // running pair, already folded below bit stride_p
  assign ops[rows_lp] = sum_i >> stride_p;
  assign ops[rows_lp+1] = carry_i >> stride_p;

  assign sum_w[0] = ops[0];
  assign carry_w[0] = ops[1];

  // chain of 3:2 adders, one operand per stage
  for (genvar k = 0; k < rows_lp; k++) begin : g_csa
    assign sum_w[k+1] = sum_w[k] ^ carry_w[k] ^ ops[k+2];
    assign carry_w[k+1] = ((sum_w[k] & carry_w[k])
                          | (sum_w[k] & ops[k+2])
                          | (carry_w[k] & ops[k+2])) << 1;
  end

  assign sum_o = sum_w[rows_lp];
  assign carry_o = carry_w[rows_lp];

endmodule

// ==== logic/booth_final_adder.sv ====
// carry-select adder building the high product half one chunk per cycle
`timescale 1ns/100ps

module booth_final_adder #(
  parameter int width_p = 32,
  parameter int cpa_stride_p = 16
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic cpa_first_i,
  input  logic cpa_i,
  input  logic [cpa_stride_p-1:0] chunk_a_i,
  input  logic [cpa_stride_p-1:0] chunk_b_i,
  input  logic tail_carry_i,
  output logic [width_p-1:0] result_high_o
);

  logic [cpa_stride_p:0] sum_zero;
  logic [cpa_stride_p:0] sum_one;
  logic [cpa_stride_p:0] sum_sel;
  logic carry_in;
  logic carry_r;
  logic [width_p-1:0] high_r;

  // both carry-in cases computed up front
  assign sum_zero = {1'b0, chunk_a_i} + {1'b0, chunk_b_i};
  assign sum_one = {1'b0, chunk_a_i} + {1'b0, chunk_b_i} + (cpa_stride_p + 1)'(1);

  // first chunk takes its carry from the low fold
  assign carry_in = cpa_first_i ? tail_carry_i : carry_r;
  assign sum_sel = carry_in ? sum_one : sum_zero;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      carry_r <= 1'b0;
    end else if (cpa_i) begin
      carry_r <= sum_sel[cpa_stride_p];
    end
  end

  always_ff @(posedge clk_i) begin
    if (cpa_i) begin
      high_r <= (high_r >> cpa_stride_p)
              | (width_p'(sum_sel[cpa_stride_p-1:0]) << (width_p - cpa_stride_p));
    end
  end

  assign result_high_o = high_r;

endmodule

// ==== logic/booth_mul_control.sv ====
// phase FSM, iteration and final-add counters, handshake and datapath strobes
`timescale 1ns/100ps

module booth_mul_control #(
  parameter int calc_steps_p = 4,
  parameter int cpa_steps_p = 2
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic yumi_i,
  output logic ready_o,
  output logic v_o,
  output logic start_o,
  output logic calc_o,
  output logic cpa_first_o,
  output logic cpa_o
);

  localparam int calc_cnt_w_lp = (calc_steps_p > 1) ? $clog2(calc_steps_p) : 1;
  localparam int cpa_cnt_w_lp = (cpa_steps_p > 1) ? $clog2(cpa_steps_p) : 1;

  booth_pkg::mul_state_e state_r;
  booth_pkg::mul_state_e state_n;
  logic [calc_cnt_w_lp-1:0] calc_cnt_r;
  logic [cpa_cnt_w_lp-1:0] cpa_cnt_r;
  logic calc_last;
  logic cpa_last;

  assign calc_last = calc_cnt_r == calc_cnt_w_lp'(calc_steps_p - 1);
  assign cpa_last = cpa_cnt_r == cpa_cnt_w_lp'(cpa_steps_p - 1);

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      booth_pkg::IDLE: begin
        if (v_i) begin
          state_n = booth_pkg::CALC;
        end
      end
      booth_pkg::CALC: begin
        if (calc_last) begin
          state_n = booth_pkg::FINAL_ADD;
        end
      end
      booth_pkg::FINAL_ADD: begin
        if (cpa_last) begin
          state_n = booth_pkg::DONE;
        end
      end
      booth_pkg::DONE: begin
        // result leaves only when the consumer takes it
        if (yumi_i) begin
          state_n = booth_pkg::IDLE;
        end
      end
      default: state_n = booth_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= booth_pkg::IDLE;
      calc_cnt_r <= '0;
      cpa_cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (start_o) begin
        calc_cnt_r <= '0;
        cpa_cnt_r <= '0;
      end else if (calc_o) begin
        calc_cnt_r <= calc_cnt_r + 1'b1;
      end else if (cpa_o) begin
        cpa_cnt_r <= cpa_cnt_r + 1'b1;
      end
    end
  end

  assign ready_o = state_r == booth_pkg::IDLE;
  assign v_o = state_r == booth_pkg::DONE;
  assign start_o = ready_o & v_i;
  assign calc_o = state_r == booth_pkg::CALC;
  assign cpa_o = state_r == booth_pkg::FINAL_ADD;
  assign cpa_first_o = cpa_o & (cpa_cnt_r == '0);

endmodule

// ==== logic/booth_mul_iterative.sv ====
// iterative radix-4 booth multiplier top, controller and datapath chain
`timescale 1ns/100ps

module booth_mul_iterative #(
  parameter int width_p = booth_pkg::DEFAULT_WIDTH_P,
  parameter int stride_p = booth_pkg::DEFAULT_STRIDE_P,
  parameter int cpa_stride_p = booth_pkg::DEFAULT_CPA_STRIDE_P
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [width_p-1:0] opa_i,
  input  logic [width_p-1:0] opb_i,
  input  logic signed_i,
  input  logic v_i,
  input  logic yumi_i,
  output logic ready_o,
  output logic [2*width_p-1:0] result_o,
  output logic v_o
);

  logic start;
  logic calc;
  logic cpa_first;
  logic cpa;
  booth_pkg::booth_digit_t [width_p/2:0] digits;
  logic [width_p:0] opa_ext;
  logic [width_p+3:0] first_row;
  logic [cpa_stride_p-1:0] chunk_a;
  logic [cpa_stride_p-1:0] chunk_b;
  logic tail_carry;
  logic [width_p-1:0] result_low;
  logic [width_p-1:0] result_high;

  booth_mul_control #(
    .calc_steps_p(width_p / stride_p),
    .cpa_steps_p(width_p / cpa_stride_p)
  ) control_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(v_i),
    .yumi_i(yumi_i),
    .ready_o(ready_o),
    .v_o(v_o),
    .start_o(start),
    .calc_o(calc),
    .cpa_first_o(cpa_first),
    .cpa_o(cpa)
  );

  booth_recoder #(
    .width_p(width_p)
  ) recoder_i (
    .opa_i(opa_i),
    .opb_i(opb_i),
    .signed_i(signed_i),
    .digits_o(digits),
    .opa_ext_o(opa_ext),
    .first_row_o(first_row)
  );

  booth_accumulator #(
    .width_p(width_p),
    .stride_p(stride_p),
    .cpa_stride_p(cpa_stride_p)
  ) accumulator_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .start_i(start),
    .calc_i(calc),
    .cpa_first_i(cpa_first),
    .cpa_i(cpa),
    .digits_i(digits),
    .opa_ext_i(opa_ext),
    .first_row_i(first_row),
    .chunk_a_o(chunk_a),
    .chunk_b_o(chunk_b),
    .tail_carry_o(tail_carry),
    .result_low_o(result_low)
  );

  booth_final_adder #(
    .width_p(width_p),
    .cpa_stride_p(cpa_stride_p)
  ) final_adder_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cpa_first_i(cpa_first),
    .cpa_i(cpa),
    .chunk_a_i(chunk_a),
    .chunk_b_i(chunk_b),
    .tail_carry_i(tail_carry),
    .result_high_o(result_high)
  );

  assign result_o = {result_high, result_low};

endmodule

// ==== logic/booth_partial_product.sv ====
// one booth partial product row with its sign-extension prefix
`timescale 1ns/100ps

module booth_partial_product #(
  parameter int width_p = 32,
  parameter bit initial_p = 1'b0
) (
  input  logic [width_p:0] multiplicand_i,
  input  booth_pkg::booth_digit_t digit_i,
  output logic [width_p+2+initial_p:0] row_o
);

  logic [width_p:0] inverted;
  logic [width_p:0] masked;
  logic [width_p:0] shifted;
  logic ext_sign;

  // the +1 of a negated row goes in below the next row
  assign inverted = digit_i.negative ? ~multiplicand_i : multiplicand_i;
  assign masked = digit_i.nonzero ? inverted : '0;
  // doubling shifts the negate bit in at the bottom
  assign shifted = digit_i.double ? {masked[width_p-1:0], digit_i.negative} : masked;
  // sign taken before the shift since 2A can need one more bit
  assign ext_sign = masked[width_p];

  if (initial_p) begin : g_leading
    assign row_o = {~ext_sign, ext_sign, ext_sign, shifted};
  end else begin : g_inner
    assign row_o = {1'b1, ~ext_sign, shifted};
  end

endmodule

// ==== logic/booth_pkg.sv ====
// booth digit struct, multiplier phase enum, default operand and stride sizes
package booth_pkg;

  // one radix-4 digit, value 0, +-1 or +-2
  typedef struct packed {
    logic negative;
    logic double;
    logic nonzero;
  } booth_digit_t;

  localparam int BOOTH_DIGIT_W = $bits(booth_digit_t);

  // phases of one multiply
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    FINAL_ADD,
    DONE
  } mul_state_e;

  // operand width, multiplier bits per iteration, high-half adder chunk
  localparam int DEFAULT_WIDTH_P = 32;
  localparam int DEFAULT_STRIDE_P = 8;
  localparam int DEFAULT_CPA_STRIDE_P = 16;

endpackage

// ==== logic/booth_recoder.sv ====
// operand sign extension, radix-4 digit recoding and leading partial product row
`timescale 1ns/100ps

module booth_recoder #(
  parameter int width_p = 32
) (
  input  logic [width_p-1:0] opa_i,
  input  logic [width_p-1:0] opb_i,
  input  logic signed_i,
  output booth_pkg::booth_digit_t [width_p/2:0] digits_o,
  output logic [width_p:0] opa_ext_o,
  output logic [width_p+3:0] first_row_o
);

  logic opb_sign;
  logic [width_p+2:0] opb_ext;

  // window is {b(2i+1), b(2i), b(2i-1)}
  function automatic booth_pkg::booth_digit_t encode(input logic [2:0] window);
    booth_pkg::booth_digit_t digit;
    digit.negative = window[2] & ~(window[1] & window[0]);
    digit.double = (window == 3'b011) | (window == 3'b100);
    digit.nonzero = (window != 3'b000) & (window != 3'b111);
    return digit;
  endfunction

  assign opb_sign = signed_i & opb_i[width_p-1];
  assign opb_ext = {opb_sign, opb_sign, opb_i, 1'b0};
  assign opa_ext_o = {signed_i & opa_i[width_p-1], opa_i};

  for (genvar i = 0; i <= width_p / 2; i++) begin : g_digit
    assign digits_o[i] = encode(opb_ext[2*i +: 3]);
  end

  // digit 0 starts the accumulation with the leading sign pattern
  booth_partial_product #(
    .width_p(width_p),
    .initial_p(1'b1)
  ) first_pp_i (
    .multiplicand_i(opa_ext_o),
    .digit_i(digits_o[0]),
    .row_o(first_row_o)
  );

endmodule
